/* source/gc_pkg.sv */
// shared opcode and intake types plus default sizes for the DRAM request scheduler
package gc_pkg;

    // request and command opcode
    typedef enum logic
    {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_t;

    // write burst intake FSM
    typedef enum logic
    {
        IDLE    = 1'b0,
        COLLECT = 1'b1
    } intake_state_t;

    // default sizes, overridden from the top level
    localparam int BEAT_W     = 16;
    localparam int BEATS      = 4;
    localparam int ADDR_W     = 10;
    localparam int REQ_DEPTH  = 4;
    localparam int FLUSH_MARK = 3;
    localparam int RDQ_DEPTH  = 4;
    localparam int STALL_MARK = 3;

endpackage

/* source/sync_fifo.sv */
// synchronous circular FIFO with look-ahead head word and occupancy count
module sync_fifo
#(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
)
(
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_push,
    input  logic                       i_pop,
    input  logic [WIDTH-1:0]           i_data,
    output logic [WIDTH-1:0]           o_data,
    output logic                       o_full,
    output logic                       o_empty,
    output logic [$clog2(DEPTH+1)-1:0] o_count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign o_empty = (o_count == '0);
    assign o_full  = (o_count == ($clog2(DEPTH+1))'(DEPTH));
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    // head is always visible
    assign o_data = mem[rd_ptr];

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            o_count <= o_count + do_push - do_pop;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (do_push)
            mem[wr_ptr] <= i_data;
    end

endmodule

/* source/request_intake.sv */
// request intake: takes single-beat reads and packs write bursts into full words
module request_intake
#(
    parameter int BEAT_W = gc_pkg::BEAT_W,
    parameter int BEATS  = gc_pkg::BEATS,
    parameter int ADDR_W = gc_pkg::ADDR_W
)
(
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_req_valid,
    input  gc_pkg::op_t             i_req_op,
    input  logic [ADDR_W-1:0]       i_req_addr,
    input  logic [BEAT_W-1:0]       i_req_wdata,
    input  logic                    i_rdq_full,
    input  logic                    i_wrq_full,
    input  logic                    i_flush,
    output logic                    o_req_ready,
    output logic                    o_rd_push,
    output logic [ADDR_W-1:0]       o_rd_addr,
    output logic                    o_wr_push,
    output logic [ADDR_W-1:0]       o_wr_addr,
    output logic [BEAT_W*BEATS-1:0] o_wr_word
);

    localparam int WORD_W = BEAT_W * BEATS;
    localparam int CNT_W  = (BEATS > 1) ? $clog2(BEATS) : 1;

    gc_pkg::intake_state_t state;
    logic [CNT_W-1:0]      beat_cnt;
    logic                  run;
    logic                  xfer;
    logic [ADDR_W-1:0]     addr_q;
    logic [WORD_W-1:0]     word_q;

    // queue flags lag a push by one cycle, so hold ready off while one is in flight.
    // once a burst has started, ready stays up until its last beat
    assign o_req_ready = (state == gc_pkg::COLLECT) ||
                         (run && !i_rdq_full && !i_wrq_full && !i_flush &&
                          !o_rd_push && !o_wr_push);
    assign xfer = i_req_valid && o_req_ready;

    assign o_rd_addr = addr_q;
    assign o_wr_addr = addr_q;
    assign o_wr_word = word_q;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state     <= gc_pkg::IDLE;
            beat_cnt  <= '0;
            run       <= 1'b0;
            o_rd_push <= 1'b0;
            o_wr_push <= 1'b0;
        end
        else
        begin
            run       <= 1'b1;
            o_rd_push <= 1'b0;
            o_wr_push <= 1'b0;
            if (xfer && state == gc_pkg::IDLE)
            begin
                if (i_req_op == gc_pkg::OP_READ)
                begin
                    o_rd_push <= 1'b1;
                end
                else
                begin
                    state    <= gc_pkg::COLLECT;
                    beat_cnt <= CNT_W'(1);
                end
            end
            else if (xfer)
            begin
                // last beat closes the burst
                if (beat_cnt == CNT_W'(BEATS - 1))
                begin
                    state     <= gc_pkg::IDLE;
                    o_wr_push <= 1'b1;
                end
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // beats shift in from the top, so beat 0 ends up lowest
    always_ff @(posedge i_clk)
    begin
        if (xfer && state == gc_pkg::IDLE)
            addr_q <= i_req_addr;
        if (xfer)
            word_q <= {i_req_wdata, word_q[WORD_W-1:BEAT_W]};
    end

endmodule

/* source/pending_write_buffer.sv */
// write queue with per-slot address compare for read-after-write and flush control
module pending_write_buffer
#(
    parameter int BEAT_W     = gc_pkg::BEAT_W,
    parameter int BEATS      = gc_pkg::BEATS,
    parameter int ADDR_W     = gc_pkg::ADDR_W,
    parameter int REQ_DEPTH  = gc_pkg::REQ_DEPTH,
    parameter int FLUSH_MARK = gc_pkg::FLUSH_MARK
)
(
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_wr_push,
    input  logic [ADDR_W-1:0]       i_wr_addr,
    input  logic [BEAT_W*BEATS-1:0] i_wr_word,
    input  logic                    i_rd_check,
    input  logic [ADDR_W-1:0]       i_rd_addr,
    input  logic                    i_pop,
    output logic [ADDR_W-1:0]       o_head_addr,
    output logic [BEAT_W*BEATS-1:0] o_head_word,
    output logic                    o_empty,
    output logic                    o_full,
    output logic                    o_flush
);

    localparam int WORD_W = BEAT_W * BEATS;
    localparam int PTR_W  = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
    localparam int CNT_W  = $clog2(REQ_DEPTH + 1);

    logic [ADDR_W-1:0]    addr_mem [REQ_DEPTH];
    logic [WORD_W-1:0]    word_mem [REQ_DEPTH];
    logic [REQ_DEPTH-1:0] slot_valid;
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;
    logic [CNT_W-1:0]     count_next;
    logic                 do_push;
    logic                 do_pop;
    logic                 raw_hit;

    assign o_empty     = (count == '0);
    assign o_full      = (count == CNT_W'(REQ_DEPTH));
    assign do_push     = i_wr_push && !o_full;
    assign do_pop      = i_pop && !o_empty;
    assign o_head_addr = addr_mem[rd_ptr];
    assign o_head_word = word_mem[rd_ptr];
    assign count_next  = count + do_push - do_pop;

    // pushed read against every live slot
    always_comb
    begin
        raw_hit = 1'b0;
        for (int i = 0; i < REQ_DEPTH; i++)
        begin
            if (i_rd_check && slot_valid[i] && addr_mem[i] == i_rd_addr)
                raw_hit = 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            slot_valid <= '0;
            o_flush    <= 1'b0;
        end
        else
        begin
            if (do_push)
            begin
                slot_valid[wr_ptr] <= 1'b1;
                wr_ptr <= (wr_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                slot_valid[rd_ptr] <= 1'b0;
                rd_ptr <= (rd_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;

            // flush holds until the queue has drained
            if (raw_hit || count_next >= CNT_W'(FLUSH_MARK))
                o_flush <= 1'b1;
            else if (count_next == '0)
                o_flush <= 1'b0;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (do_push)
        begin
            addr_mem[wr_ptr] <= i_wr_addr;
            word_mem[wr_ptr] <= i_wr_word;
        end
    end

endmodule

/* source/command_arbiter.sv */
// read/write queue arbiter, issues one registered command per backend ready cycle
module command_arbiter
#(
    parameter int BEAT_W = gc_pkg::BEAT_W,
    parameter int BEATS  = gc_pkg::BEATS,
    parameter int ADDR_W = gc_pkg::ADDR_W
)
(
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_cmd_ready,
    input  logic                    i_rdq_empty,
    input  logic [ADDR_W-1:0]       i_rdq_addr,
    input  logic                    i_wrq_empty,
    input  logic [ADDR_W-1:0]       i_wrq_addr,
    input  logic [BEAT_W*BEATS-1:0] i_wrq_word,
    input  logic                    i_flush,
    output logic                    o_rdq_pop,
    output logic                    o_wrq_pop,
    output logic                    o_cmd_valid,
    output gc_pkg::op_t             o_cmd_op,
    output logic [ADDR_W-1:0]       o_cmd_addr,
    output logic [BEAT_W*BEATS-1:0] o_cmd_wdata
);

    logic take;
    logic sel_wr;

    // writes go first in flush mode or when no read waits
    assign sel_wr    = !i_wrq_empty && (i_flush || i_rdq_empty);
    assign take      = i_cmd_ready && (!i_rdq_empty || !i_wrq_empty);
    assign o_wrq_pop = take && sel_wr;
    assign o_rdq_pop = take && !sel_wr;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_cmd_valid <= 1'b0;
        else
            o_cmd_valid <= take;
    end

    always_ff @(posedge i_clk)
    begin
        if (take)
        begin
            o_cmd_op    <= sel_wr ? gc_pkg::OP_WRITE : gc_pkg::OP_READ;
            o_cmd_addr  <= sel_wr ? i_wrq_addr : i_rdq_addr;
            o_cmd_wdata <= i_wrq_word;
        end
    end

endmodule

/* source/read_return_path.sv */
// read return path: captures backend words, queues them and sends them out beat by beat
module read_return_path
#(
    parameter int BEAT_W     = gc_pkg::BEAT_W,
    parameter int BEATS      = gc_pkg::BEATS,
    parameter int RDQ_DEPTH  = gc_pkg::RDQ_DEPTH,
    parameter int STALL_MARK = gc_pkg::STALL_MARK
)
(
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_ret_valid,
    input  logic [BEAT_W*BEATS-1:0] i_ret_data,
    input  logic                    i_rd_ready,
    output logic                    o_ret_ready,
    output logic                    o_rd_valid,
    output logic [BEAT_W-1:0]       o_rd_data
);

    localparam int WORD_W = BEAT_W * BEATS;
    localparam int OCC_W  = $clog2(RDQ_DEPTH + 1);
    localparam int BCNT_W = (BEATS > 1) ? $clog2(BEATS) : 1;

    logic              take;
    logic              cap_valid;
    logic [WORD_W-1:0] cap_data;
    logic [WORD_W-1:0] rdq_word;
    logic              rdq_empty;
    logic              rdq_pop;
    logic [OCC_W-1:0]  rdq_count;
    logic [OCC_W:0]    fill;
    logic              stall;
    logic              fire;
    logic [BCNT_W-1:0] beat_cnt;

    //////////////////////////////////////////////////
    // capture and stall
    //////////////////////////////////////////////////
    assign take = i_ret_valid && o_ret_ready;

    // count words still in flight, ready reacts a cycle late
    assign fill  = rdq_count + cap_valid + take;
    assign stall = (fill >= (OCC_W + 1)'(STALL_MARK));

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            cap_valid   <= 1'b0;
            o_ret_ready <= 1'b0;
        end
        else
        begin
            cap_valid   <= take;
            o_ret_ready <= !stall;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (take)
            cap_data <= i_ret_data;
    end

    sync_fifo #(
        .WIDTH (WORD_W),
        .DEPTH (RDQ_DEPTH)
    ) u_rd_data_q (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (cap_valid),
        .i_pop   (rdq_pop),
        .i_data  (cap_data),
        .o_data  (rdq_word),
        .o_full  (),
        .o_empty (rdq_empty),
        .o_count (rdq_count)
    );

    //////////////////////////////////////////////////
    // beat serializer
    //////////////////////////////////////////////////
    assign fire    = i_rd_ready && !rdq_empty;
    assign rdq_pop = fire && (beat_cnt == BCNT_W'(BEATS - 1));

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            beat_cnt   <= '0;
            o_rd_valid <= 1'b0;
        end
        else
        begin
            o_rd_valid <= fire;
            if (rdq_pop)
                beat_cnt <= '0;
            else if (fire)
                beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // beat 0 first, lowest bits
    always_ff @(posedge i_clk)
    begin
        if (fire)
            o_rd_data <= rdq_word[beat_cnt*BEAT_W +: BEAT_W];
    end

endmodule

/* source/global_controller.sv */
// DRAM front-end request scheduler top level between one requester and one bank controller
module global_controller
#(
    parameter int BEAT_W     = gc_pkg::BEAT_W,
    parameter int BEATS      = gc_pkg::BEATS,
    parameter int ADDR_W     = gc_pkg::ADDR_W,
    parameter int REQ_DEPTH  = gc_pkg::REQ_DEPTH,
    parameter int FLUSH_MARK = gc_pkg::FLUSH_MARK,
    parameter int RDQ_DEPTH  = gc_pkg::RDQ_DEPTH,
    parameter int STALL_MARK = gc_pkg::STALL_MARK
)
(
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    // requester request side
    input  logic                    i_req_valid,
    input  gc_pkg::op_t             i_req_op,
    input  logic [ADDR_W-1:0]       i_req_addr,
    input  logic [BEAT_W-1:0]       i_req_wdata,
    output logic                    o_req_ready,
    // backend command side
    input  logic                    i_cmd_ready,
    output logic                    o_cmd_valid,
    output gc_pkg::op_t             o_cmd_op,
    output logic [ADDR_W-1:0]       o_cmd_addr,
    output logic [BEAT_W*BEATS-1:0] o_cmd_wdata,
    // backend return side
    input  logic                    i_ret_valid,
    input  logic [BEAT_W*BEATS-1:0] i_ret_data,
    output logic                    o_ret_ready,
    // requester read side
    input  logic                    i_rd_ready,
    output logic                    o_rd_valid,
    output logic [BEAT_W-1:0]       o_rd_data
);

    localparam int WORD_W = BEAT_W * BEATS;

    logic              rd_push;
    logic [ADDR_W-1:0] rd_addr;
    logic              wr_push;
    logic [ADDR_W-1:0] wr_addr;
    logic [WORD_W-1:0] wr_word;
    logic              rdq_pop;
    logic              rdq_full;
    logic              rdq_empty;
    logic [ADDR_W-1:0] rdq_addr;
    logic              wrq_pop;
    logic              wrq_full;
    logic              wrq_empty;
    logic [ADDR_W-1:0] wrq_addr;
    logic [WORD_W-1:0] wrq_word;
    logic              wr_flush;

    //////////////////////////////////////////////////
    // request side
    //////////////////////////////////////////////////
    request_intake #(
        .BEAT_W (BEAT_W),
        .BEATS  (BEATS),
        .ADDR_W (ADDR_W)
    ) u_intake (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_req_valid (i_req_valid),
        .i_req_op    (i_req_op),
        .i_req_addr  (i_req_addr),
        .i_req_wdata (i_req_wdata),
        .i_rdq_full  (rdq_full),
        .i_wrq_full  (wrq_full),
        .i_flush     (wr_flush),
        .o_req_ready (o_req_ready),
        .o_rd_push   (rd_push),
        .o_rd_addr   (rd_addr),
        .o_wr_push   (wr_push),
        .o_wr_addr   (wr_addr),
        .o_wr_word   (wr_word)
    );

    // read request queue
    sync_fifo #(
        .WIDTH (ADDR_W),
        .DEPTH (REQ_DEPTH)
    ) u_rd_req_q (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (rd_push),
        .i_pop   (rdq_pop),
        .i_data  (rd_addr),
        .o_data  (rdq_addr),
        .o_full  (rdq_full),
        .o_empty (rdq_empty),
        .o_count ()
    );

    pending_write_buffer #(
        .BEAT_W     (BEAT_W),
        .BEATS      (BEATS),
        .ADDR_W     (ADDR_W),
        .REQ_DEPTH  (REQ_DEPTH),
        .FLUSH_MARK (FLUSH_MARK)
    ) u_wr_buf (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wr_push   (wr_push),
        .i_wr_addr   (wr_addr),
        .i_wr_word   (wr_word),
        .i_rd_check  (rd_push),
        .i_rd_addr   (rd_addr),
        .i_pop       (wrq_pop),
        .o_head_addr (wrq_addr),
        .o_head_word (wrq_word),
        .o_empty     (wrq_empty),
        .o_full      (wrq_full),
        .o_flush     (wr_flush)
    );

    //////////////////////////////////////////////////
    // backend side
    //////////////////////////////////////////////////
    command_arbiter #(
        .BEAT_W (BEAT_W),
        .BEATS  (BEATS),
        .ADDR_W (ADDR_W)
    ) u_arbiter (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cmd_ready (i_cmd_ready),
        .i_rdq_empty (rdq_empty),
        .i_rdq_addr  (rdq_addr),
        .i_wrq_empty (wrq_empty),
        .i_wrq_addr  (wrq_addr),
        .i_wrq_word  (wrq_word),
        .i_flush     (wr_flush),
        .o_rdq_pop   (rdq_pop),
        .o_wrq_pop   (wrq_pop),
        .o_cmd_valid (o_cmd_valid),
        .o_cmd_op    (o_cmd_op),
        .o_cmd_addr  (o_cmd_addr),
        .o_cmd_wdata (o_cmd_wdata)
    );

    read_return_path #(
        .BEAT_W     (BEAT_W),
        .BEATS      (BEATS),
        .RDQ_DEPTH  (RDQ_DEPTH),
        .STALL_MARK (STALL_MARK)
    ) u_ret_path (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_ret_valid (i_ret_valid),
        .i_ret_data  (i_ret_data),
        .i_rd_ready  (i_rd_ready),
        .o_ret_ready (o_ret_ready),
        .o_rd_valid  (o_rd_valid),
        .o_rd_data   (o_rd_data)
    );

endmodule

/* tb/global_controller_assert.sv */
// protocol checks for the request scheduler, bound into the top level
module global_controller_assert
(
    input logic i_clk,
    input logic i_rst_n,
    input logic i_cmd_ready,
    input logic o_cmd_valid,
    input logic o_req_ready,
    input logic i_flush,
    input logic o_rd_valid
);

    // a command pulse needs backend ready in the cycle before
    cmd_after_ready : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_cmd_valid |-> $past(i_cmd_ready))
        else $error("command issued without backend ready");

    // no new requests while the write queue drains
    no_req_in_flush : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_flush |-> !o_req_ready)
        else $error("requester ready high during flush");

    rd_quiet_after_reset : assert property (@(posedge i_clk)
        $rose(i_rst_n) |-> !o_rd_valid)
        else $error("read valid high right after reset");

endmodule

bind global_controller global_controller_assert u_proto_check (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_cmd_ready (i_cmd_ready),
    .o_cmd_valid (o_cmd_valid),
    .o_req_ready (o_req_ready),
    .i_flush     (wr_flush),
    .o_rd_valid  (o_rd_valid)
);

/* tb/tb_global_controller.sv */
// testbench for the DRAM request scheduler with a file-driven requester and a backend memory model
module tb_global_controller;

    localparam int BEAT_W       = gc_pkg::BEAT_W;
    localparam int BEATS        = gc_pkg::BEATS;
    localparam int ADDR_W       = gc_pkg::ADDR_W;
    localparam int WORD_W       = BEAT_W * BEATS;
    localparam int STALL_MARK   = gc_pkg::STALL_MARK;
    localparam int FLUSH_MARK   = gc_pkg::FLUSH_MARK;
    localparam int COLS         = 10;
    localparam int MAX_LINES    = 40;
    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DLY    = 2;
    localparam int CYCLE_BUDGET = 80;

    logic              i_clk;
    logic              i_rst_n;
    logic              i_req_valid;
    gc_pkg::op_t       i_req_op;
    logic [ADDR_W-1:0] i_req_addr;
    logic [BEAT_W-1:0] i_req_wdata;
    logic              o_req_ready;
    logic              i_cmd_ready;
    logic              o_cmd_valid;
    gc_pkg::op_t       o_cmd_op;
    logic [ADDR_W-1:0] o_cmd_addr;
    logic [WORD_W-1:0] o_cmd_wdata;
    logic              i_ret_valid;
    logic [WORD_W-1:0] i_ret_data;
    logic              o_ret_ready;
    logic              i_rd_ready;
    logic              o_rd_valid;
    logic [BEAT_W-1:0] o_rd_data;

    logic [15:0]       prog [COLS*MAX_LINES];
    int                n_lines;
    int                seed;
    int                cycle;
    int                ret_taken;
    bit                loaded;
    bit                hold_rd = 1'b1;

    // write queue tracking for the watermark flush
    int                wr_sent;
    int                wr_sent_d;
    int                wr_issued;
    bit                flush_exp;
    bit                hold_cmd;

    // expected traffic built from the data file
    logic [ADDR_W-1:0] exp_wr_addr [$];
    logic [WORD_W-1:0] exp_wr_word [$];
    logic [ADDR_W-1:0] exp_rd_addr [$];
    logic [BEAT_W-1:0] exp_beat [$];

    // backend model state
    logic [WORD_W-1:0] backend_mem [2**ADDR_W];
    logic [WORD_W-1:0] ret_word [$];
    int                ret_due [$];

    global_controller #(
        .BEAT_W     (gc_pkg::BEAT_W),
        .BEATS      (gc_pkg::BEATS),
        .ADDR_W     (gc_pkg::ADDR_W),
        .REQ_DEPTH  (gc_pkg::REQ_DEPTH),
        .FLUSH_MARK (gc_pkg::FLUSH_MARK),
        .RDQ_DEPTH  (gc_pkg::RDQ_DEPTH),
        .STALL_MARK (gc_pkg::STALL_MARK)
    ) DUT (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_req_valid (i_req_valid),
        .i_req_op    (i_req_op),
        .i_req_addr  (i_req_addr),
        .i_req_wdata (i_req_wdata),
        .o_req_ready (o_req_ready),
        .i_cmd_ready (i_cmd_ready),
        .o_cmd_valid (o_cmd_valid),
        .o_cmd_op    (o_cmd_op),
        .o_cmd_addr  (o_cmd_addr),
        .o_cmd_wdata (o_cmd_wdata),
        .i_ret_valid (i_ret_valid),
        .i_ret_data  (i_ret_data),
        .o_ret_ready (o_ret_ready),
        .i_rd_ready  (i_rd_ready),
        .o_rd_valid  (o_rd_valid),
        .o_rd_data   (o_rd_data)
    );

    initial
    begin
        i_clk = 1'b0;
    end

    always #(CLK_PERIOD/2) i_clk = ~i_clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp)
            stop_run($sformatf("[FAIL] t=%0t %s: got %h expected %h", $time, what, got, exp));
    endtask

    // scan the program up to the end marker and queue the expected traffic
    task automatic load_program();
        int               base;
        logic [WORD_W-1:0] word;
        n_lines = 0;
        while (n_lines < MAX_LINES && prog[n_lines*COLS] !== 16'hffff)
        begin
            base = n_lines * COLS;
            if (prog[base][0])
            begin
                for (int b = 0; b < BEATS; b++)
                    word[b*BEAT_W +: BEAT_W] = prog[base+2+b][BEAT_W-1:0];
                exp_wr_addr.push_back(prog[base+1][ADDR_W-1:0]);
                exp_wr_word.push_back(word);
            end
            else
            begin
                exp_rd_addr.push_back(prog[base+1][ADDR_W-1:0]);
                for (int b = 0; b < BEATS; b++)
                    exp_beat.push_back(prog[base+6+b][BEAT_W-1:0]);
            end
            n_lines++;
        end
    endtask

    // a write next to another write in the program
    function automatic bit in_write_run(input int idx);
        bit prev_wr;
        bit next_wr;
        prev_wr = (idx > 0) && prog[(idx-1)*COLS][0];
        next_wr = (idx + 1 < n_lines) && prog[(idx+1)*COLS][0];
        return prog[idx*COLS][0] && (prev_wr || next_wr);
    endfunction

    // one beat for a read and a full burst for a write
    task automatic send_request(input int idx);
        int base;
        int nbeats;
        base   = idx * COLS;
        nbeats = prog[base][0] ? BEATS : 1;
        for (int b = 0; b < nbeats; b++)
        begin
            i_req_valid = 1'b1;
            i_req_op    = gc_pkg::op_t'(prog[base][0]);
            i_req_addr  = prog[base+1][ADDR_W-1:0];
            i_req_wdata = prog[base+2+b][BEAT_W-1:0];
            @(negedge i_clk);
            while (!o_req_ready)
                @(negedge i_clk);
            @(posedge i_clk);
            #DRIVE_DLY;
        end
        if (prog[base][0])
            wr_sent++;
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial
    begin
        seed        = 32'h3f8cf1a4;
        cycle       = 0;
        ret_taken   = 0;
        wr_sent     = 0;
        wr_sent_d   = 0;
        wr_issued   = 0;
        flush_exp   = 1'b0;
        hold_cmd    = 1'b0;
        i_rst_n     = 1'b0;
        i_req_valid = 1'b0;
        i_req_op    = gc_pkg::OP_READ;
        i_req_addr  = '0;
        i_req_wdata = '0;
        i_cmd_ready = 1'b0;
        i_ret_valid = 1'b0;
        i_ret_data  = '0;
        i_rd_ready  = 1'b0;
        // fill pattern with beat k in the top nibble and the address below
        for (int a = 0; a < 2**ADDR_W; a++)
            for (int k = 0; k < BEATS; k++)
                backend_mem[a][k*BEAT_W +: BEAT_W] = BEAT_W'(k * 4096 + a);
        $readmemh("tb/global_controller_testdata.txt", prog);
        load_program();
        if (n_lines == 0)
            stop_run("the test data file holds no requests");
        loaded = 1'b1;
        repeat (2) @(posedge i_clk);
        #DRIVE_DLY;
        i_rst_n = 1'b1;
        for (int i = 0; i < n_lines; i++)
        begin
            hold_cmd = in_write_run(i);
            send_request(i);
        end
        hold_cmd    = 1'b0;
        i_req_valid = 1'b0;
        while (exp_beat.size() != 0 || exp_wr_addr.size() != 0 || exp_rd_addr.size() != 0)
            @(negedge i_clk);
        repeat (4) @(negedge i_clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

    // random backend and requester readiness plus due return words
    always @(posedge i_clk)
    begin
        logic [31:0] r;
        #DRIVE_DLY;
        if (i_rst_n)
        begin
            r           = $random(seed);
            // writes in a run stay queued until the watermark flush starts
            i_cmd_ready = (r[1:0] != 2'b00) && !(hold_cmd && !flush_exp);
            i_rd_ready  = !hold_rd && (r[3:2] != 2'b00);
            if (ret_word.size() != 0 && cycle >= ret_due[0])
            begin
                i_ret_valid = 1'b1;
                i_ret_data  = ret_word[0];
            end
            else
                i_ret_valid = 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // monitors sampled mid-cycle
    //////////////////////////////////////////////////
    always @(negedge i_clk)
    begin
        logic [31:0] d;
        cycle++;
        if (i_rst_n)
        begin
            if (o_cmd_valid && o_cmd_op == gc_pkg::OP_WRITE)
            begin
                if (exp_wr_addr.size() == 0)
                    stop_run("the backend saw a write command that was never requested");
                check_value(64'(o_cmd_addr), 64'(exp_wr_addr.pop_front()), "write address");
                check_value(64'(o_cmd_wdata), 64'(exp_wr_word.pop_front()), "write data");
                backend_mem[o_cmd_addr] = o_cmd_wdata;
                wr_issued++;
            end
            else if (o_cmd_valid)
            begin
                if (exp_rd_addr.size() == 0)
                    stop_run("the backend saw a read command that was never requested");
                check_value(64'(o_cmd_addr), 64'(exp_rd_addr.pop_front()), "read address");
                d = $random(seed);
                ret_word.push_back(backend_mem[o_cmd_addr]);
                ret_due.push_back(cycle + int'(d[2:0]));
            end
            // a write sits in the queue from the cycle after its last beat
            if (wr_sent_d - wr_issued >= FLUSH_MARK)
                flush_exp = 1'b1;
            else if (wr_sent_d == wr_issued)
                flush_exp = 1'b0;
            if (flush_exp)
                check_value(64'(o_req_ready), 64'(0), "request ready during write flush");
            wr_sent_d = wr_sent;
            // word leaves the backend at the next edge
            if (i_ret_valid && o_ret_ready)
            begin
                void'(ret_word.pop_front());
                void'(ret_due.pop_front());
                ret_taken++;
            end
            if (o_rd_valid)
            begin
                if (exp_beat.size() == 0)
                    stop_run("the requester received a read beat that was never expected");
                check_value(64'(o_rd_data), 64'(exp_beat.pop_front()), "read beat");
            end
        end
    end

    // hold the requester read side until the return path stalls
    initial
    begin
        wait (ret_taken >= STALL_MARK);
        repeat (2) @(negedge i_clk);
        check_value(64'(o_ret_ready), 64'(0), "return ready under read stall");
        hold_rd = 1'b0;
    end

    initial
    begin
        wait (loaded);
        #(n_lines * CYCLE_BUDGET * CLK_PERIOD);
        stop_run("timeout: the run did not finish within its cycle budget");
    end

endmodule

/* tb/global_controller_testdata.txt */
// op addr wbeat0 wbeat1 wbeat2 wbeat3 expbeat0 expbeat1 expbeat2 expbeat3
// op 0 read, 1 write, ffff ends the program
0 010 0000 0000 0000 0000 0010 1010 2010 3010
0 011 0000 0000 0000 0000 0011 1011 2011 3011
0 012 0000 0000 0000 0000 0012 1012 2012 3012
0 013 0000 0000 0000 0000 0013 1013 2013 3013
1 020 aa01 aa02 aa03 aa04 0000 0000 0000 0000
0 020 0000 0000 0000 0000 aa01 aa02 aa03 aa04
1 030 b001 b002 b003 b004 0000 0000 0000 0000
1 031 b101 b102 b103 b104 0000 0000 0000 0000
1 032 b201 b202 b203 b204 0000 0000 0000 0000
0 031 0000 0000 0000 0000 b101 b102 b103 b104
1 010 c001 c002 c003 c004 0000 0000 0000 0000
0 010 0000 0000 0000 0000 c001 c002 c003 c004
0 040 0000 0000 0000 0000 0040 1040 2040 3040
1 041 d001 d002 d003 d004 0000 0000 0000 0000
1 042 d101 d102 d103 d104 0000 0000 0000 0000
0 041 0000 0000 0000 0000 d001 d002 d003 d004
0 042 0000 0000 0000 0000 d101 d102 d103 d104
1 020 e001 e002 e003 e004 0000 0000 0000 0000
0 020 0000 0000 0000 0000 e001 e002 e003 e004
0 1ff 0000 0000 0000 0000 01ff 11ff 21ff 31ff
1 032 f001 f002 f003 f004 0000 0000 0000 0000
0 032 0000 0000 0000 0000 f001 f002 f003 f004
ffff 0 0 0 0 0 0 0 0 0

/* project.f */
source/gc_pkg.sv
source/sync_fifo.sv
source/request_intake.sv
source/pending_write_buffer.sv
source/command_arbiter.sv
source/read_return_path.sv
source/global_controller.sv
tb/global_controller_assert.sv
tb/tb_global_controller.sv

/* run_sim.sh */
#!/bin/sh
# build and run the scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_global_controller -f project.f -o sim_tb; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
    exit 0
fi
exit 1
